// ==== flist.f ====
+incdir+src
src/isa_pkg.sv
src/pipe_pkg.sv
src/mips_decoder.sv
src/alu_execute.sv
src/reg_writeback.sv
src/int_pipe_top.sv
testbench/int_pipe_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps
TOP       ?= int_pipe_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the simulation with Verilator, run it and check the outcome"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); status=$$?; echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	if echo "$$out" | grep -q "^test failed$$"; then exit 1; fi; \
	echo "$$out" | grep -q "^test passed$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== testbench/int_pipe_tb.sv ====
`timescale 1ns/1ps

module int_pipe_tb;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int CLK_PERIOD = 20;
    localparam int NUM_TESTS = 6;
    localparam int MAX_INSTR = 200;    // Upper bound on instructions issued by all tests.

    localparam logic [5:0] R_FUNCS [16] = '{F_SLL, F_SRL, F_SRA, F_SLLV, F_SRLV, F_SRAV,
        F_ADD, F_ADDU, F_SUB, F_SUBU, F_AND, F_OR, F_XOR, F_NOR, F_SLT, F_SLTU};
    localparam logic [5:0] I_OPS [8] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
        OP_ANDI, OP_ORI, OP_XORI, OP_LUI};

    logic       clk;
    logic       rst;
    logic       instr_valid;
    word_t      instr;
    wb_result_t result;

    word_t      mregs [32] = '{default: '0};    // Architectural register state.
    wb_result_t exp_q [$];
    int         edge_q [$];
    int         cyc = 0;
    int         errors = 0;
    int         checks = 0;
    int         ntests = 0;
    int         nfail = 0;

    int_pipe_top UUT (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .result      (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    initial begin
        #((MAX_INSTR + 10 * NUM_TESTS + 20) * CLK_PERIOD);
        $display("timeout: the tests did not complete in the expected time");
        $display("test failed");
        $finish;
    end

    function automatic word_t rtype(input logic [5:0] f, input logic [4:0] rd,
                                    input logic [4:0] rs, input logic [4:0] rt,
                                    input logic [4:0] sh);
        return {6'h00, rs, rt, rd, sh, f};
    endfunction

    function automatic word_t itype(input logic [5:0] op, input logic [4:0] rt,
                                    input logic [4:0] rs, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // Executes one instruction on the architectural state.
    function automatic wb_result_t model_step(input word_t w);
        wb_result_t  r;
        word_t       a;
        word_t       b;
        word_t       simm;
        word_t       zimm;
        logic [32:0] s;
        a = mregs[w[25:21]];
        b = mregs[w[20:16]];
        simm = {{16{w[15]}}, w[15:0]};
        zimm = {16'h0000, w[15:0]};
        r = '0;
        r.valid = 1'b1;
        if (w[31:26] == 6'h00) begin
            r.dst = w[15:11];
            case (w[5:0])
                F_SLL:  r.data = b << w[10:6];
                F_SRL:  r.data = b >> w[10:6];
                F_SRA:  r.data = $signed(b) >>> w[10:6];
                F_SLLV: r.data = b << a[4:0];
                F_SRLV: r.data = b >> a[4:0];
                F_SRAV: r.data = $signed(b) >>> a[4:0];
                F_ADD, F_SUB: begin
                    s = (w[5:0] == F_ADD) ? {a[31], a} + {b[31], b} : {a[31], a} - {b[31], b};
                    r.data = s[31:0];
                    r.exc_ov = s[32] ^ s[31];    // 33-bit result leaves the word range.
                end
                F_ADDU: r.data = a + b;
                F_SUBU: r.data = a - b;
                F_AND:  r.data = a & b;
                F_OR:   r.data = a | b;
                F_XOR:  r.data = a ^ b;
                F_NOR:  r.data = ~(a | b);
                F_SLT:  r.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                F_SLTU: r.data = (a < b) ? 32'd1 : 32'd0;
                default: r.exc_ri = 1'b1;
            endcase
        end else begin
            r.dst = w[20:16];
            case (w[31:26])
                OP_ADDI: begin
                    s = {a[31], a} + {simm[31], simm};
                    r.data = s[31:0];
                    r.exc_ov = s[32] ^ s[31];
                end
                OP_ADDIU: r.data = a + simm;
                OP_SLTI:  r.data = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
                OP_SLTIU: r.data = (a < simm) ? 32'd1 : 32'd0;
                OP_ANDI:  r.data = a & zimm;
                OP_ORI:   r.data = a | zimm;
                OP_XORI:  r.data = a ^ zimm;
                OP_LUI:   r.data = {w[15:0], 16'h0000};
                default:  r.exc_ri = 1'b1;
            endcase
        end
        if (r.exc_ri) begin
            r.dst = '0;
        end
        r.regwrite = !r.exc_ri && !r.exc_ov;
        if (r.regwrite && r.dst != '0) begin
            mregs[r.dst] = r.data;
        end
        return r;
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (exp === act) else begin
            $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
            errors++;
        end
    endtask

    always @(negedge clk) begin
        wb_result_t exp_r;
        if (!rst && result.valid) begin
            assert (exp_q.size() != 0) else begin
                $display("%0t ns: result.valid rose with no instruction in flight", $time);
                errors++;
            end
            if (exp_q.size() != 0) begin
                exp_r = exp_q.pop_front();
                check_field("result latency edge", edge_q.pop_front(), cyc);
                check_field("result.regwrite", 32'(exp_r.regwrite), 32'(result.regwrite));
                check_field("result.exc_ri", 32'(exp_r.exc_ri), 32'(result.exc_ri));
                check_field("result.exc_ov", 32'(exp_r.exc_ov), 32'(result.exc_ov));
                if (!exp_r.exc_ri) begin
                    check_field("result.dst", 32'(exp_r.dst), 32'(result.dst));
                end
                if (exp_r.regwrite) begin
                    check_field("result.data", exp_r.data, result.data);
                end
            end
        end
    end

    task automatic issue(input word_t w);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr <= w;
        exp_q.push_back(model_step(w));
        edge_q.push_back(cyc + 3);    // Sampled at the next edge, registered one edge later.
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            instr_valid <= 1'b0;
        end
    endtask

    task automatic drain();
        int n;
        n = 0;
        idle(1);
        while (exp_q.size() != 0 && n < 8) begin
            @(posedge clk);
            n++;
        end
        assert (exp_q.size() == 0) else begin
            $display("%0d issued instructions never produced a result", exp_q.size());
            errors++;
        end
    endtask

    task automatic report(input string name, input int start);
        ntests++;
        if (errors == start) begin
            $display("%s: ok", name);
        end else begin
            nfail++;
            $display("%s: FAILED with %0d errors", name, errors - start);
        end
    endtask

    task automatic test_reset();
        int start;
        start = errors;
        @(negedge clk);
        check_field("result.valid", 32'd0, 32'(result.valid));
        for (int i = 0; i < 32; i++) begin
            issue(rtype(F_OR, 5'(i), 5'(i), 5'd0, 5'd0));
        end
        drain();
        report("reset", start);
    endtask

    task automatic test_itype();
        int start;
        start = errors;
        issue(itype(OP_ADDIU, 1, 0, 16'hfffb));
        issue(itype(OP_SLTI, 2, 1, 16'hfffc));
        issue(itype(OP_SLTIU, 3, 1, 16'hfffc));
        issue(itype(OP_ANDI, 4, 1, 16'hff0f));    // Upper half must come back clear.
        issue(itype(OP_ORI, 5, 0, 16'h8001));
        issue(itype(OP_XORI, 6, 5, 16'hffff));
        issue(itype(OP_LUI, 7, 0, 16'h8123));
        idle(3);
        issue(rtype(F_ADDU, 8, 7, 6, 0));    // Read back from the register file.
        drain();
        report("itype", start);
    endtask

    task automatic test_rtype();
        int start;
        start = errors;
        issue(itype(OP_LUI, 9, 0, 16'h8000));
        issue(itype(OP_ORI, 9, 9, 16'h00f0));
        issue(itype(OP_ADDIU, 10, 0, 16'h0024));    // Variable shifts use only bits 4:0.
        issue(rtype(F_SLL, 11, 0, 9, 4));
        issue(rtype(F_SLLV, 12, 10, 9, 0));
        issue(rtype(F_SRL, 13, 0, 9, 4));
        issue(rtype(F_SRLV, 14, 10, 9, 0));
        issue(rtype(F_SRA, 15, 0, 9, 4));
        issue(rtype(F_SRAV, 16, 10, 9, 0));
        issue(rtype(F_AND, 17, 9, 10, 0));
        issue(rtype(F_OR, 18, 9, 10, 0));
        issue(rtype(F_XOR, 19, 9, 10, 0));
        issue(rtype(F_NOR, 20, 9, 10, 0));
        issue(rtype(F_SLT, 21, 9, 10, 0));
        issue(rtype(F_SLTU, 22, 9, 10, 0));
        issue(rtype(F_SUBU, 23, 10, 9, 0));
        drain();
        report("rtype", start);
    endtask

    task automatic test_bypass();
        int start;
        start = errors;
        issue(itype(OP_ADDIU, 1, 0, 16'h0007));
        for (int i = 1; i < 11; i++) begin
            issue(rtype(F_ADDU, 5'(i + 1), 5'(i), 5'(i), 5'd0));
        end
        drain();
        report("bypass", start);
    endtask

    task automatic test_exceptions();
        int start;
        start = errors;
        issue(itype(OP_ADDIU, 15, 0, 16'h0123));
        issue(itype(OP_LUI, 14, 0, 16'h7fff));
        issue(itype(OP_ORI, 14, 14, 16'hffff));
        issue(itype(OP_LUI, 16, 0, 16'h8000));
        issue(itype(OP_ADDI, 15, 14, 16'h0001));
        issue(rtype(F_ADD, 15, 14, 14, 0));
        issue(rtype(F_SUB, 15, 16, 14, 0));
        issue(rtype(F_ADDU, 18, 15, 0, 0));    // Right behind the overflows.
        issue(rtype(F_ADDU, 17, 14, 14, 0));
        issue(itype(OP_ADDIU, 0, 0, 16'h0055));
        issue(rtype(F_OR, 19, 0, 0, 0));
        drain();
        report("exceptions", start);
    endtask

    task automatic test_reserved_random();
        int         start;
        logic [4:0] rd;
        logic [4:0] rs;
        logic [4:0] rt;
        start = errors;
        issue({6'h23, 5'd0, 5'd20, 16'h0010});    // LW.
        issue({6'h04, 5'd0, 5'd20, 16'h0002});    // BEQ.
        issue({6'h02, 26'h0000040});    // J.
        issue(rtype(6'h18, 0, 0, 1, 0));    // MULT.
        issue(rtype(6'h0c, 0, 0, 0, 0));    // SYSCALL.
        issue(rtype(F_OR, 21, 20, 0, 0));
        repeat (100) begin
            rd = 5'($urandom);
            rs = 5'($urandom);
            rt = 5'($urandom);
            if ($urandom % 3 != 0) begin
                issue(rtype(R_FUNCS[4'($urandom)], rd, rs, rt, 5'($urandom)));
            end else begin
                issue(itype(I_OPS[3'($urandom)], rt, rs, 16'($urandom)));
            end
        end
        drain();
        report("reserved and random", start);
    endtask

    initial begin
        void'($urandom(5));
        rst = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_itype();
        test_rtype();
        test_bypass();
        test_exceptions();
        test_reserved_random();
        $display("%0d tests, %0d failed, %0d checks, %0d errors", ntests, nfail, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== src/int_pipe_top.sv ====
`timescale 1ns/1ps

module int_pipe_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 instr_valid,
    input  isa_pkg::word_t       instr,
    output pipe_pkg::wb_result_t result
);
    import isa_pkg::*;
    import pipe_pkg::*;

    decoded_instr_t dec;
    wb_result_t     ex_out;
    word_t          rdata1;
    word_t          rdata2;

    mips_decoder u_decoder (
        .instr (instr),
        .dec   (dec)
    );

    alu_execute u_execute (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .dec         (dec),
        .rdata1      (rdata1),
        .rdata2      (rdata2),
        .ex_out      (ex_out)
    );

    reg_writeback u_writeback (
        .clk    (clk),
        .rst    (rst),
        .raddr1 (dec.src1),
        .raddr2 (dec.src2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .ex_out (ex_out),
        .result (result)
    );

endmodule

// ==== src/reg_writeback.sv ====
`timescale 1ns/1ps
`include "mips_params.svh"

module reg_writeback (
    input  logic                 clk,
    input  logic                 rst,
    input  isa_pkg::areg_addr_t  raddr1,
    input  isa_pkg::areg_addr_t  raddr2,
    output isa_pkg::word_t       rdata1,
    output isa_pkg::word_t       rdata2,
    input  pipe_pkg::wb_result_t ex_out,
    output pipe_pkg::wb_result_t result
);
    import isa_pkg::*;

    word_t regs [`NUM_AREGS];
    logic  wr_en;

    assign wr_en = ex_out.valid && ex_out.regwrite && (ex_out.dst != '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `NUM_AREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[ex_out.dst] <= ex_out.data;
        end
    end

    // r0 is hardwired.
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else begin
            result <= ex_out;
        end
    end

    // First edge out of reset loads whatever execute presents.
    assert property (@(posedge clk) $fell(rst) |=> !result.valid)
        else $error("writeback: result valid in the cycle after reset");

endmodule

// ==== src/alu_execute.sv ====
`timescale 1ns/1ps
`include "mips_params.svh"

module alu_execute (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     instr_valid,
    input  pipe_pkg::decoded_instr_t dec,
    input  isa_pkg::word_t           rdata1,
    input  isa_pkg::word_t           rdata2,
    output pipe_pkg::wb_result_t     ex_out
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic                 valid_q;
    decoded_instr_t       dec_q;
    word_t                a_q;
    word_t                b_q;
    word_t                op_b;
    word_t                sum;
    word_t                diff;
    word_t                alu_res;
    logic [`SHAMT_W-1:0]  shamt;
    logic                 fwd1;
    logic                 fwd2;
    logic                 ovf;

    // Only the instruction in this stage can be newer than the register file.
    assign fwd1 = ex_out.regwrite && (ex_out.dst != '0) && (ex_out.dst == dec.src1);
    assign fwd2 = ex_out.regwrite && (ex_out.dst != '0) && (ex_out.dst == dec.src2);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= instr_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            dec_q <= dec;
            a_q <= fwd1 ? ex_out.data : rdata1;
            b_q <= fwd2 ? ex_out.data : rdata2;
        end
    end

    assign op_b  = dec_q.use_imm ? dec_q.imm : b_q;
    assign shamt = dec_q.shamt_valid ? dec_q.imm[`SHAMT_W-1:0] : a_q[`SHAMT_W-1:0];
    assign sum   = a_q + op_b;
    assign diff  = a_q - op_b;

    always_comb begin
        case (dec_q.alufunc)
            ALU_ADD, ALU_ADDU: alu_res = sum;
            ALU_SUB, ALU_SUBU: alu_res = diff;
            ALU_SLT:  alu_res = {{(`WORD_W-1){1'b0}}, $signed(a_q) < $signed(op_b)};
            ALU_SLTU: alu_res = {{(`WORD_W-1){1'b0}}, a_q < op_b};
            ALU_AND:  alu_res = a_q & op_b;
            ALU_OR:   alu_res = a_q | op_b;
            ALU_XOR:  alu_res = a_q ^ op_b;
            ALU_NOR:  alu_res = ~(a_q | op_b);
            ALU_SLL:  alu_res = op_b << shamt;
            ALU_SRL:  alu_res = op_b >> shamt;
            ALU_SRA:  alu_res = $signed(op_b) >>> shamt;   // Sign fill.
            ALU_LUI:  alu_res = op_b << 16;
            default:  alu_res = '0;
        endcase
    end

    // Signed overflow, only the trapping add and subtract.
    always_comb begin
        case (dec_q.alufunc)
            ALU_ADD: ovf = (a_q[`WORD_W-1] == op_b[`WORD_W-1]) &&
                           (sum[`WORD_W-1] != a_q[`WORD_W-1]);
            ALU_SUB: ovf = (a_q[`WORD_W-1] != op_b[`WORD_W-1]) &&
                           (diff[`WORD_W-1] != a_q[`WORD_W-1]);
            default: ovf = 1'b0;
        endcase
    end

    assign ex_out.valid    = valid_q;
    assign ex_out.regwrite = valid_q && dec_q.regwrite && !ovf;
    assign ex_out.dst      = dec_q.dst;
    assign ex_out.data     = alu_res;
    assign ex_out.exc_ri   = valid_q && dec_q.exc_ri;
    assign ex_out.exc_ov   = valid_q && ovf;

    assert property (@(posedge clk) disable iff (rst)
        (ex_out.exc_ov || ex_out.exc_ri) |-> !ex_out.regwrite)
        else $error("execute: excepting instruction still writes a register");

endmodule

// ==== src/mips_decoder.sv ====
`timescale 1ns/1ps
`include "mips_params.svh"

module mips_decoder (
    input  isa_pkg::word_t          instr,
    output pipe_pkg::decoded_instr_t dec
);
    import isa_pkg::*;
    import pipe_pkg::*;

    op_t        op;
    func_t      func;
    areg_addr_t rs;
    areg_addr_t rt;
    areg_addr_t rd;
    logic       zeroext;
    logic       exc_ri;

    assign op   = op_t'(instr[31:26]);
    assign func = func_t'(instr[5:0]);
    assign rs   = instr[25:21];
    assign rt   = instr[20:16];
    assign rd   = instr[15:11];

    assign zeroext = (op == OP_ANDI) || (op == OP_ORI) || (op == OP_XORI);

    always_comb begin
        dec = '0;
        exc_ri = 1'b0;
        case (op)
            OP_RT: begin
                case (func)
                    F_SLL:   dec.alufunc = ALU_SLL;
                    F_SRL:   dec.alufunc = ALU_SRL;
                    F_SRA:   dec.alufunc = ALU_SRA;
                    F_SLLV:  dec.alufunc = ALU_SLL;
                    F_SRLV:  dec.alufunc = ALU_SRL;
                    F_SRAV:  dec.alufunc = ALU_SRA;
                    F_ADD:   dec.alufunc = ALU_ADD;
                    F_ADDU:  dec.alufunc = ALU_ADDU;
                    F_SUB:   dec.alufunc = ALU_SUB;
                    F_SUBU:  dec.alufunc = ALU_SUBU;
                    F_AND:   dec.alufunc = ALU_AND;
                    F_OR:    dec.alufunc = ALU_OR;
                    F_XOR:   dec.alufunc = ALU_XOR;
                    F_NOR:   dec.alufunc = ALU_NOR;
                    F_SLT:   dec.alufunc = ALU_SLT;
                    F_SLTU:  dec.alufunc = ALU_SLTU;
                    default: exc_ri = 1'b1;         // MULT, JR, SYSCALL and friends.
                endcase
            end
            OP_ADDI:  dec.alufunc = ALU_ADD;
            OP_ADDIU: dec.alufunc = ALU_ADDU;
            OP_SLTI:  dec.alufunc = ALU_SLT;
            OP_SLTIU: dec.alufunc = ALU_SLTU;
            OP_ANDI:  dec.alufunc = ALU_AND;
            OP_ORI:   dec.alufunc = ALU_OR;
            OP_XORI:  dec.alufunc = ALU_XOR;
            OP_LUI:   dec.alufunc = ALU_LUI;
            default:  exc_ri = 1'b1;
        endcase

        dec.src1 = rs;
        dec.shamt_valid = (op == OP_RT) && (func == F_SLL || func == F_SRL || func == F_SRA);
        if (dec.shamt_valid) begin
            dec.imm = {{(`WORD_W-`SHAMT_W){1'b0}}, instr[10:6]};
        end else if (zeroext) begin
            dec.imm = {{(`WORD_W-`IMM_W){1'b0}}, instr[15:0]};
        end else begin
            dec.imm = {{(`WORD_W-`IMM_W){instr[15]}}, instr[15:0]};
        end

        if (op == OP_RT) begin
            dec.src2 = rt;
            dec.dst = rd;
        end else begin
            dec.use_imm = 1'b1;                 // I-type, rt is the target.
            dec.dst = rt;
        end

        dec.exc_ri = exc_ri;
        dec.regwrite = !exc_ri;
        if (exc_ri) begin
            dec.dst = '0;
        end
    end

    // Kept opcodes are SPECIAL and the 001xxx immediate group.
    always_comb begin
        assert (!dec.regwrite || instr[31:26] == 6'h00 || instr[31:29] == 3'b001)
            else $error("decoder: dropped opcode marked for register write");
    end

endmodule

// ==== src/pipe_pkg.sv ====
package pipe_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_ADDU,
        ALU_SUB,
        ALU_SUBU,
        ALU_SLT,
        ALU_SLTU,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_NOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_LUI
    } alu_func_t;

    // Decoder output, captured by the execute stage.
    typedef struct packed {
        alu_func_t            alufunc;
        logic                 regwrite;
        isa_pkg::areg_addr_t  dst;
        isa_pkg::areg_addr_t  src1;
        isa_pkg::areg_addr_t  src2;
        logic                 use_imm;
        isa_pkg::word_t       imm;      // Extended immediate or shift amount.
        logic                 shamt_valid;
        logic                 exc_ri;
    } decoded_instr_t;

    typedef struct packed {
        logic                 valid;
        logic                 regwrite;
        isa_pkg::areg_addr_t  dst;
        isa_pkg::word_t       data;
        logic                 exc_ri;
        logic                 exc_ov;
    } wb_result_t;

endpackage

// ==== src/isa_pkg.sv ====
`include "mips_params.svh"

package isa_pkg;

    typedef logic [`WORD_W-1:0] word_t;
    typedef logic [`AREG_W-1:0] areg_addr_t;

    // Primary opcode, instr[31:26].
    typedef enum logic [5:0] {
        OP_RT    = 6'h00,
        OP_ADDI  = 6'h08,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0a,
        OP_SLTIU = 6'h0b,
        OP_ANDI  = 6'h0c,
        OP_ORI   = 6'h0d,
        OP_XORI  = 6'h0e,
        OP_LUI   = 6'h0f
    } op_t;

    // Function code for OP_RT, instr[5:0].
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_SRL  = 6'h02,
        F_SRA  = 6'h03,
        F_SLLV = 6'h04,
        F_SRLV = 6'h06,
        F_SRAV = 6'h07,
        F_ADD  = 6'h20,
        F_ADDU = 6'h21,
        F_SUB  = 6'h22,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_NOR  = 6'h27,
        F_SLT  = 6'h2a,
        F_SLTU = 6'h2b
    } func_t;

endpackage

// ==== src/mips_params.svh ====
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Data path and instruction word width.
`define WORD_W 32

// Architectural register file geometry.
`define AREG_W 5
`define NUM_AREGS 32

// Shift amount field width, instr[10:6].
`define SHAMT_W 5

// Width of the 16-bit immediate field.
`define IMM_W 16

`endif
